/* verilog.f */
+incdir+bench
hw/mod461_pkg.sv
hw/mod461_wb_regs.sv
hw/chunk_residue_stage.sv
hw/residue_adder_tree.sv
hw/residue_fold.sv
hw/mod461_reducer.sv
bench/mod461_tb.sv

/* bench/wb_bus_tasks.svh */
`ifndef WB_BUS_TASKS_SVH
`define WB_BUS_TASKS_SVH

// Entered and left 2 ns after a rising edge, so accesses can run back to back
task automatic bus_access(input logic [4:0] addr, input logic write,
		input logic [31:0] wdata, output logic [31:0] rdata);
	int n;
	n = 0;
	rdata = '0;
	cyc = 1'b1;
	stb = 1'b1;
	we = write;
	adr = addr;
	dat_w = wdata;
	@(negedge clk);
	while (!ack && n < ACK_LIMIT)
	begin
		n++;
		@(negedge clk);
	end
	if (ack)
		rdata = dat_r;	// Mid-cycle, well away from the edges
	else
	begin
		other_errors++;
		$display("No ack from the DUT for address %0d at %0t", addr, $time);
	end
	@(posedge clk);
	#2;
	cyc = 1'b0;
	stb = 1'b0;
	we = 1'b0;
endtask

task automatic bus_write(input logic [4:0] addr, input logic [31:0] wdata);
	logic [31:0] unused;
	bus_access(addr, 1'b1, wdata, unused);
endtask

task automatic bus_read(input logic [4:0] addr, output logic [31:0] rdata);
	bus_access(addr, 1'b0, '0, rdata);
endtask

task automatic wait_done();
	logic [31:0] st;
	int polls;
	st = '0;
	polls = 0;
	while (!st[0] && polls < POLL_LIMIT)
	begin
		bus_read(ADDR_STATUS, st);
		polls++;
	end
	if (!st[0])
	begin
		other_errors++;
		$display("Done bit still clear after %0d status reads at %0t", POLL_LIMIT, $time);
	end
endtask

`endif

/* bench/mod461_tb.sv */
module mod461_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [4:0] ADDR_CTRL = 5'd16;
	localparam logic [4:0] ADDR_STATUS = 5'd17;
	localparam logic [4:0] ADDR_RESULT = 5'd18;
	localparam longint POW32_MOD = 405;	// 2**32 mod 461
	localparam int N_RANDOM = 200;
	localparam int N_EDGE_MAX = 2 + 11 + 11;
	localparam int ACK_LIMIT = 8;
	localparam int POLL_LIMIT = 16;
	// About 22 accesses per reduction, 40 cycles allowed for each
	localparam int N_ACCESSES = 18 + 58 + (N_RANDOM + N_EDGE_MAX) * 22 + 60;
	localparam int MAX_CYCLES = N_ACCESSES * 40;

	logic clk;
	logic rst_n;
	logic cyc;
	logic stb;
	logic we;
	logic [4:0] adr;
	logic [31:0] dat_w;
	logic ack;
	logic [31:0] dat_r;
	logic [31:0] lfsr_state;
	int value_errors = 0;
	int other_errors = 0;
	int cycle_count = 0;

	`include "wb_bus_tasks.svh"

	mod461_reducer u_mod461_reducer (
		.clk   (clk),
		.rst_n (rst_n),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.ack   (ack),
		.dat_r (dat_r)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > MAX_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Errors: %0d value, %0d other", value_errors, other_errors);
			$display("sim failed");
			$finish;
		end
	end

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic logic [511:0] random_operand();
		logic [511:0] v;
		for (int i = 0; i < 16; i++)
			v[32*i +: 32] = rand_bits(32);
		v[511:500] = '0;
		return v;
	endfunction

	// Horner over the words, most significant first
	function automatic int model_residue(input logic [511:0] x);
		longint r;
		r = 0;
		for (int i = 15; i >= 0; i--)
			r = (r * POW32_MOD + x[32*i +: 32] % 461) % 461;
		return int'(r);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			value_errors++;
			$display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic reduce(input logic [511:0] x, output logic [31:0] res);
		for (int i = 0; i < 16; i++)
			bus_write(5'(i), x[32*i +: 32]);
		bus_write(ADDR_CTRL, 32'h1);
		wait_done();
		bus_read(ADDR_RESULT, res);
	endtask

	task automatic check_reduction(input logic [511:0] x);
		logic [31:0] res;
		reduce(x, res);
		check_value("result", res, model_residue(x));
	endtask

	initial
	begin
		logic [511:0] x;
		logic [31:0] w;
		logic [31:0] res;
		int n;
		int off;
		clk = 1'b0;
		rst_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		lfsr_state = 32'd92;
		repeat (8) @(posedge clk);
		#2;
		rst_n = 1'b1;

		bus_read(ADDR_STATUS, w);
		check_value("status", w, 32'h0);
		bus_read(ADDR_RESULT, w);
		check_value("result", w, 32'h0);
		for (int i = 0; i < 16; i++)
		begin
			bus_read(5'(i), w);
			check_value("operand word", w, 32'h0);
		end

		// Readback, with stray writes to unmapped addresses in between
		for (int i = 0; i < 16; i++)
		begin
			x[32*i +: 32] = rand_bits(32);
			bus_write(5'(i), x[32*i +: 32]);
		end
		for (int a = 19; a < 32; a++)
			bus_write(5'(a), rand_bits(32));
		for (int i = 0; i < 16; i++)
		begin
			bus_read(5'(i), w);
			check_value("operand word", w, (i == 15) ? x[511:480] & 32'hF_FFFF : x[32*i +: 32]);
		end
		for (int a = 19; a < 32; a++)
		begin
			bus_read(5'(a), w);
			check_value("unmapped read", w, 32'h0);
		end

		repeat (N_RANDOM)
			check_reduction(random_operand());

		x = '0;
		check_reduction(x);
		x[499:0] = '1;
		check_reduction(x);
		n = 4 + rand_bits(3);
		repeat (n)
		begin
			x = '0;
			x[rand_bits(9) % 500] = 1'b1;
			check_reduction(x);
		end
		n = 4 + rand_bits(3);
		repeat (n)
		begin
			x = random_operand();
			x[511:480] = '0;
			off = rand_bits(16) % 461;
			x = x * 461 + off;	// Known residue
			check_value("model residue", model_residue(x), off);
			reduce(x, res);
			check_value("result", res, off);
		end

		// Words rewritten right after a start
		x = random_operand();
		for (int i = 0; i < 16; i++)
			bus_write(5'(i), x[32*i +: 32]);
		bus_write(ADDR_CTRL, 32'h1);
		bus_read(ADDR_STATUS, w);
		check_value("status", w, 32'h2);
		for (int i = 0; i < 4; i++)
			bus_write(5'(i), ~x[32*i +: 32]);
		wait_done();
		bus_read(ADDR_RESULT, res);
		check_value("result", res, model_residue(x));

		// Second start lands while the first is still in the pipeline
		for (int i = 0; i < 4; i++)
			x[32*i +: 32] = ~x[32*i +: 32];
		bus_write(ADDR_CTRL, 32'h1);
		x[31:0] = ~x[31:0];
		bus_write(5'd0, x[31:0]);
		bus_write(ADDR_CTRL, 32'h1);
		bus_read(ADDR_STATUS, w);
		check_value("status", w, 32'h2);
		wait_done();
		bus_read(ADDR_STATUS, w);
		check_value("status", w, 32'h1);
		bus_read(ADDR_RESULT, res);
		check_value("result", res, model_residue(x));

		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* hw/mod461_reducer.sv */
module mod461_reducer (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cyc,
	input  logic                 stb,
	input  logic                 we,
	input  mod461_pkg::wb_addr_t adr,
	input  mod461_pkg::wb_data_t dat_w,
	output logic                 ack,
	output mod461_pkg::wb_data_t dat_r
);

	import mod461_pkg::*;

	logic start;
	logic chunk_valid;
	logic sum_valid;
	logic res_valid;
	operand_t operand;
	residue_t [N_CHUNKS-1:0] chunk_res;
	partial_sum_t [N_GROUPS-1:0] partial_sums;
	residue_t residue;

	mod461_wb_regs u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.cyc       (cyc),
		.stb       (stb),
		.we        (we),
		.adr       (adr),
		.dat_w     (dat_w),
		.ack       (ack),
		.dat_r     (dat_r),
		.res_valid (res_valid),
		.residue   (residue),
		.start     (start),
		.operand   (operand)
	);

	// Three register stages, result three cycles after start
	chunk_residue_stage u_chunks (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.operand     (operand),
		.chunk_valid (chunk_valid),
		.chunk_res   (chunk_res)
	);

	residue_adder_tree u_tree (
		.clk          (clk),
		.rst_n        (rst_n),
		.chunk_valid  (chunk_valid),
		.chunk_res    (chunk_res),
		.sum_valid    (sum_valid),
		.partial_sums (partial_sums)
	);

	residue_fold u_fold (
		.clk          (clk),
		.rst_n        (rst_n),
		.sum_valid    (sum_valid),
		.partial_sums (partial_sums),
		.res_valid    (res_valid),
		.residue      (residue)
	);

endmodule

/* hw/residue_fold.sv */
module residue_fold (
	input  logic                                                clk,
	input  logic                                                rst_n,
	input  logic                                                sum_valid,
	input  mod461_pkg::partial_sum_t [mod461_pkg::N_GROUPS-1:0] partial_sums,
	output logic                                                res_valid,
	output mod461_pkg::residue_t                                residue
);

	import mod461_pkg::*;

	partial_sum_t [N_GROUPS-1:0] folded;
	partial_sum_t pair_lo;
	partial_sum_t pair_hi;
	partial_sum_t total;
	residue_t residue_d;

	always_comb
	begin
		for (int i = 0; i < N_GROUPS; i++)
			folded[i] = fold_461({1'b0, partial_sums[i]});	// Each below 1277
		pair_lo = fold_461({1'b0, folded[0] + folded[1]});
		pair_hi = fold_461({1'b0, folded[2] + folded[3]});

		// Last fold leaves at most 613, so one subtraction is enough
		total = fold_461({1'b0, pair_lo + pair_hi});
		if (total >= MODULUS)
			residue_d = residue_t'(total - MODULUS);
		else
			residue_d = residue_t'(total);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			res_valid <= 1'b0;
		else
			res_valid <= sum_valid;
	end

	always_ff @(posedge clk)
	begin
		residue <= residue_d;
	end

endmodule

/* hw/residue_adder_tree.sv */
module residue_adder_tree (
	input  logic                                                clk,
	input  logic                                                rst_n,
	input  logic                                                chunk_valid,
	input  mod461_pkg::residue_t [mod461_pkg::N_CHUNKS-1:0]     chunk_res,
	output logic                                                sum_valid,
	output mod461_pkg::partial_sum_t [mod461_pkg::N_GROUPS-1:0] partial_sums
);

	import mod461_pkg::*;

	// Chunks 1..81 go through three levels of triples: 27, 9, 3
	logic [RES_W+1:0] lvl1 [27];
	partial_sum_t lvl2 [9];
	logic [SUM_W:0] lvl3 [3];
	partial_sum_t [N_GROUPS-1:0] sums_d;

	always_comb
	begin
		for (int i = 0; i < 27; i++)
			lvl1[i] = chunk_res[3*i+1] + chunk_res[3*i+2] + chunk_res[3*i+3];
		for (int i = 0; i < 9; i++)
			lvl2[i] = lvl1[3*i] + lvl1[3*i+1] + lvl1[3*i+2];
		for (int i = 0; i < 3; i++)
		begin
			lvl3[i] = lvl2[3*i] + lvl2[3*i+1] + lvl2[3*i+2];
			// 27 residues can reach 12420, fold back under SUM_W
			sums_d[i] = fold_461(lvl3[i]);
		end
		// Leftover chunks plus the raw low chunk
		sums_d[N_GROUPS-1] = chunk_res[N_CHUNKS-2] + chunk_res[N_CHUNKS-1] + chunk_res[0];
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sum_valid <= 1'b0;
		else
			sum_valid <= chunk_valid;
	end

	always_ff @(posedge clk)
	begin
		partial_sums <= sums_d;
	end

endmodule

/* hw/chunk_residue_stage.sv */
module chunk_residue_stage (
	input  logic                                            clk,
	input  logic                                            rst_n,
	input  logic                                            start,
	input  mod461_pkg::operand_t                            operand,
	output logic                                            chunk_valid,
	output mod461_pkg::residue_t [mod461_pkg::N_CHUNKS-1:0] chunk_res
);

	import mod461_pkg::*;

	residue_t [N_CHUNKS-1:0] res_d;

	// Entry v holds v * 2**(6k) mod 461
	function automatic logic [(2**CHUNK_W)*RES_W-1:0] build_table(input int k);
		logic [(2**CHUNK_W)*RES_W-1:0] tbl;
		int w;
		w = 1;
		for (int i = 0; i < k; i++)
			w = (w << CHUNK_W) % MODULUS;
		for (int v = 0; v < 2**CHUNK_W; v++)
			tbl[v*RES_W +: RES_W] = residue_t'((v * w) % MODULUS);
		return tbl;
	endfunction

	for (genvar k = 0; k < N_CHUNKS; k++)
	begin : g_chunk
		logic [CHUNK_W-1:0] chunk;

		if (k == N_CHUNKS - 1)
		begin : g_top
			// Two bits left, only four table entries reachable
			assign chunk = CHUNK_W'(operand[OPERAND_W-1:k*CHUNK_W]);
		end
		else
		begin : g_body
			assign chunk = operand[k*CHUNK_W +: CHUNK_W];
		end

		if (k == 0)
		begin : g_raw
			assign res_d[k] = residue_t'(chunk);	// Weight 1, already below 461
		end
		else
		begin : g_lut
			localparam logic [(2**CHUNK_W)*RES_W-1:0] TBL = build_table(k);
			assign res_d[k] = TBL[chunk*RES_W +: RES_W];
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			chunk_valid <= 1'b0;
		else
			chunk_valid <= start;
	end

	always_ff @(posedge clk)
	begin
		chunk_res <= res_d;
	end

endmodule

/* hw/mod461_wb_regs.sv */
module mod461_wb_regs (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cyc,
	input  logic                 stb,
	input  logic                 we,
	input  mod461_pkg::wb_addr_t adr,
	input  mod461_pkg::wb_data_t dat_w,
	output logic                 ack,
	output mod461_pkg::wb_data_t dat_r,
	input  logic                 res_valid,
	input  mod461_pkg::residue_t residue,
	output logic                 start,
	output mod461_pkg::operand_t operand
);

	import mod461_pkg::*;

	logic [N_WORDS-1:0][WB_DATA_W-1:0] words;
	logic [N_WORDS*WB_DATA_W-1:0] words_flat;
	logic [$clog2(N_WORDS)-1:0] widx;
	logic acc;
	logic wr_acc;
	logic start_acc;
	logic [1:0] inflight;
	logic busy;
	logic done;
	residue_t result;

	assign acc = cyc && stb && !ack;	// First cycle of an access
	assign wr_acc = acc && we;
	assign start_acc = wr_acc && (adr == ADDR_CTRL) && dat_w[0];
	assign widx = adr[$clog2(N_WORDS)-1:0];
	assign words_flat = words;
	assign busy = (inflight != 2'd0);

	// Single-cycle ack, no wait states
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ack <= 1'b0;
		else
			ack <= acc;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			words <= '0;
		else if (wr_acc && adr < N_WORDS)
		begin
			if (widx == N_WORDS - 1)
				words[widx] <= dat_w & TOP_MASK;	// Bits above 499 not stored
			else
				words[widx] <= dat_w;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			start <= 1'b0;
		else
			start <= start_acc;
	end

	// Snapshot, so word writes after a start don't reach the pipeline
	always_ff @(posedge clk)
	begin
		if (start_acc)
			operand <= words_flat[OPERAND_W-1:0];
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			inflight <= 2'd0;
			done <= 1'b0;
			result <= '0;
		end
		else
		begin
			case ({start_acc, res_valid})
				2'b10: inflight <= inflight + 2'd1;
				2'b01: inflight <= inflight - 2'd1;
				default: inflight <= inflight;
			endcase
			// A new start wins over a result landing in the same cycle
			if (start_acc)
				done <= 1'b0;
			else if (res_valid)
				done <= 1'b1;
			if (res_valid)
				result <= residue;	// Later result overwrites
		end
	end

	always_comb
	begin
		dat_r = '0;
		if (adr < N_WORDS)
			dat_r = words[widx];
		else if (adr == ADDR_STATUS)
			dat_r[1:0] = {busy, done};
		else if (adr == ADDR_RESULT)
			dat_r[RES_W-1:0] = result;
	end

endmodule

/* hw/mod461_pkg.sv */
package mod461_pkg;

	localparam int OPERAND_W = 500;
	localparam int CHUNK_W = 6;
	localparam int N_CHUNKS = 84;	// Top chunk holds only 2 bits
	localparam int MODULUS = 461;
	localparam int RES_W = 9;
	localparam int SUM_W = 13;
	localparam int N_GROUPS = 4;
	localparam int FOLD_HI = 51;	// 2**9 mod 461

	localparam int WB_DATA_W = 32;
	localparam int N_WORDS = 16;
	localparam int ADDR_W = 5;
	localparam int TOP_W = OPERAND_W - (N_WORDS - 1) * WB_DATA_W;

	typedef logic [OPERAND_W-1:0] operand_t;
	typedef logic [RES_W-1:0] residue_t;
	typedef logic [SUM_W-1:0] partial_sum_t;
	typedef logic [WB_DATA_W-1:0] wb_data_t;
	typedef logic [ADDR_W-1:0] wb_addr_t;

	// Register map above the operand words
	localparam wb_addr_t ADDR_CTRL = 5'd16;
	localparam wb_addr_t ADDR_STATUS = 5'd17;
	localparam wb_addr_t ADDR_RESULT = 5'd18;

	localparam wb_data_t TOP_MASK = wb_data_t'((1 << TOP_W) - 1);

	// Split at bits 6 and 9, result stays congruent mod 461
	function automatic partial_sum_t fold_461(input logic [SUM_W:0] x);
		return partial_sum_t'(x[5:0] + 64 * x[8:6] + FOLD_HI * x[SUM_W:9]);
	endfunction

endpackage
